// File: test/vec_cpu_stim.txt
// test count; per test: stream length, stream bytes FE..FF, drain cycles, readback count,
// then readbacks as src (01 reg, 00 mem), address, byte select, value, positive
05
// reset values, program is only a self loop
06 FE 63 00 00 00 FF
28 05 01 00 00 00 00 01 1F 03 00 00 01 0F 01 00 00 00 00 00 00 00 00 1F 02 00 00
// scalar ops with back-to-back dependences
22 FE 93 00 C0 06 13 81 50 03 B3 81 20 00 33 82 21 40 B3 72 22 00
33 E3 32 00 B3 83 60 40 63 00 00 00 FF
28 0B 01 01 00 6C 01 01 02 00 A1 00 01 03 00 0D 01 01 03 01 01 01
01 04 00 6C 01 01 05 00 20 01 01 06 00 2D 01 01 06 01 01 01
01 07 00 3F 01 01 07 01 FF 00 01 07 03 FF 00
// sw, lw and a dependent add
1A FE 93 00 30 7F 13 01 80 00 23 22 11 00 83 21 41 00 33 82 11 00 63 00 00 00 FF
28 07 00 03 00 F3 00 00 03 01 07 01 00 03 02 00 00 00 02 00 00 00
01 03 00 F3 00 01 04 00 E6 00 01 04 01 0F 01
// taken beq skips x4, not-taken beq runs x5
2E FE 93 00 30 00 13 01 30 00 93 01 40 00 13 00 00 00 13 00 00 00 13 00 00 00
63 84 20 00 13 02 10 01 63 84 30 00 93 02 20 02 63 00 00 00 FF
28 05 01 04 00 00 00 01 05 00 22 01 01 01 00 03 01 01 02 00 03 01 01 03 00 04 01
// vadd.b and vsub.b lanes
1E FE 93 00 00 7F 13 01 30 12 B3 01 20 40 57 82 30 00 D7 92 30 00 57 03 21 00 63 00 00 00 FF
28 0B 01 04 00 CD 00 01 04 01 05 01 01 04 02 FF 00 01 04 03 FF 00
01 05 00 13 01 01 05 01 09 01 01 05 02 01 01 01 05 03 01 01
01 06 00 46 01 01 06 01 02 01 01 06 02 00 00

// File: vec_cpu.f
hw/rv_isa_pkg.sv
hw/pipe_pkg.sv
hw/program_loader.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/vec_cpu_top.sv
test/vec_cpu_checker.sv
test/vec_cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := vec_cpu_tb
FILELIST  := vec_cpu.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/vec_cpu_tb.sv
`timescale 1ns/1ps

module vec_cpu_tb;

    localparam int STIM_DEPTH   = 1024;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_CHECKS   = 16;
    localparam int MARGIN       = 200;

    logic       clk_i;
    logic       reset;
    logic [7:0] instr_byte_i;
    logic       data_or_reg_i;
    logic [4:0] rd_addr_i;
    logic [1:0] byte_sel_i;
    logic [7:0] value_o;
    logic       is_positive_o;

    logic [7:0] stim [STIM_DEPTH];
    int         pos = 0;          // read pointer into stim
    int         cycle_limit = 0;  // set once the stim file is scanned
    int         total_checks = 0;
    int         total_errors = 0;

    vec_cpu_top UUT (.clk_i, .reset, .instr_byte_i, .data_or_reg_i, .rd_addr_i,
        .byte_sel_i, .value_o, .is_positive_o);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        int cycle_cnt;
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic int take();
        int v;
        v = int'(stim[pos]);
        pos++;
        return v;
    endfunction

    // stream + run wait + drain + readbacks, per test
    function automatic int budget_cycles();
        int p;
        int n;
        int total;
        total = MARGIN;
        p = 1;
        for (int t = 0; t < int'(stim[0]); t++) begin
            n = int'(stim[p]);
            total += RESET_CYCLES + n + 2;
            p += n + 1;
            total += int'(stim[p]);
            n = int'(stim[p + 1]);
            total += n;
            p += 2 + 5 * n;
        end
        return total;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic apply_reset();
        reset        = 1'b1;
        instr_byte_i = 8'h00;
        repeat (RESET_CYCLES) next_cycle();
        reset = 1'b0;
    endtask

    task automatic stream_program(input int n_bytes);
        for (int i = 0; i < n_bytes; i++) begin
            instr_byte_i = stim[pos];
            pos++;
            next_cycle();
        end
        instr_byte_i = 8'h00;  // idle after the end byte
    endtask

    // one readback: src, addr, byte, value, positive
    task automatic check_readback(input int at, inout int errors);
        logic [7:0] exp_val;
        logic       exp_pos;
        string      where;
        data_or_reg_i = stim[at][0];
        rd_addr_i     = stim[at + 1][4:0];
        byte_sel_i    = stim[at + 2][1:0];
        exp_val       = stim[at + 3];
        exp_pos       = stim[at + 4][0];
        #4;
        where = $sformatf("%s%0d byte %0d", data_or_reg_i ? "x" : "mem word ", rd_addr_i,
            byte_sel_i);
        if (value_o !== exp_val) begin
            $display("Fail at %0t: value_o of %s got %h expected %h", $time, where,
                value_o, exp_val);
            errors++;
        end
        if (is_positive_o !== exp_pos) begin
            $display("Fail at %0t: is_positive_o of %s got %b expected %b", $time, where,
                is_positive_o, exp_pos);
            errors++;
        end
        next_cycle();
    endtask

    initial begin
        int n_tests;
        int n_checks;
        int errors;
        int j;
        int tmp;
        int chk_at [MAX_CHECKS];
        int order [MAX_CHECKS];
        reset         = 1'b1;
        instr_byte_i  = 8'h00;
        data_or_reg_i = 1'b1;
        rd_addr_i     = 5'd0;
        byte_sel_i    = 2'd0;
        void'($urandom(17));
        $readmemh("test/vec_cpu_stim.txt", stim);
        cycle_limit = budget_cycles();
        n_tests = take();
        for (int t = 1; t <= n_tests; t++) begin
            apply_reset();  // also restarts the loader
            stream_program(take());
            while (!UUT.run)
                next_cycle();
            repeat (take()) next_cycle();  // let the pipeline drain
            n_checks = take();
            for (int k = 0; k < n_checks; k++) begin
                chk_at[k] = pos + 5 * k;
                order[k]  = k;
            end
            pos += 5 * n_checks;
            for (int i = n_checks - 1; i > 0; i--) begin
                j        = int'($urandom_range(i, 0));  // shuffle readback order
                tmp      = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
            errors = 0;
            for (int k = 0; k < n_checks; k++)
                check_readback(chk_at[order[k]], errors);
            $display("Test %0d done: %0d readbacks, %0d errors", t, n_checks, errors);
            total_checks += n_checks;
            total_errors += errors;
        end
        $display("Summary: %0d tests, %0d readbacks, %0d errors, %0d assertion failures",
            n_tests, total_checks, total_errors, UUT.u_checker.fail_cnt);
        total_errors += int'(UUT.u_checker.fail_cnt);
        if (total_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: test/vec_cpu_checker.sv
`timescale 1ns/1ps

module vec_cpu_checker (
    input logic clk_i,
    input logic reset,
    input logic run_i,
    input logic imem_we_i,
    input logic stall_i,
    input logic branch_taken_i
);
    int unsigned fail_cnt = 0;  // assertion failures so far

    // run only drops through reset
    run_held: assert property (@(posedge clk_i) disable iff (reset) run_i |=> run_i)
        else begin
            $error("run fell while reset was low");
            fail_cnt++;
        end

    no_load_while_run: assert property (@(posedge clk_i) disable iff (reset)
        !(imem_we_i && run_i))
        else begin
            $error("instruction memory written while running");
            fail_cnt++;
        end

    no_branch_in_stall: assert property (@(posedge clk_i) disable iff (reset)
        !(branch_taken_i && stall_i))
        else begin
            $error("branch taken during a load-use stall");
            fail_cnt++;
        end

endmodule

bind vec_cpu_top vec_cpu_checker u_checker (.clk_i, .reset, .run_i(run),
    .imem_we_i(imem_we), .stall_i(stall), .branch_taken_i(branch_taken));

// File: hw/vec_cpu_top.sv
`timescale 1ns/1ps

module vec_cpu_top (
    input  logic       clk_i,
    input  logic       reset,
    input  logic [7:0] instr_byte_i,
    input  logic       data_or_reg_i,  // high reads a register
    input  logic [4:0] rd_addr_i,
    input  logic [1:0] byte_sel_i,
    output logic [7:0] value_o,
    output logic       is_positive_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic               run, imem_we;
    logic [IMEM_AW-1:0] imem_waddr;
    logic [XLEN-1:0]    imem_wdata;
    logic               stall, branch_taken;
    logic [XLEN-1:0]    branch_target;
    if_id_t             if_id;
    id_ex_t             id_ex;
    ex_mem_t            ex_mem;
    logic [REG_AW-1:0]  wb_rd;
    logic [XLEN-1:0]    wb_data;
    logic               wb_we;
    logic [XLEN-1:0]    reg_dbg, mem_dbg;
    vec_word_u          rb_word;

    program_loader u_loader (.clk_i, .reset, .instr_byte_i, .imem_we_o(imem_we),
        .imem_waddr_o(imem_waddr), .imem_wdata_o(imem_wdata), .run_o(run));

    fetch_stage u_fetch (.clk_i, .reset, .run_i(run), .stall_i(stall),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .imem_we_i(imem_we), .imem_waddr_i(imem_waddr), .imem_wdata_i(imem_wdata),
        .if_id_o(if_id));

    decode_stage u_decode (.clk_i, .reset, .run_i(run), .if_id_i(if_id), .wb_rd_i(wb_rd),
        .wb_data_i(wb_data), .wb_we_i(wb_we), .dbg_addr_i(rd_addr_i), .dbg_data_o(reg_dbg),
        .stall_o(stall), .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .id_ex_o(id_ex));

    execute_stage u_execute (.clk_i, .reset, .run_i(run), .id_ex_i(id_ex), .wb_rd_i(wb_rd),
        .wb_data_i(wb_data), .wb_we_i(wb_we), .ex_mem_o(ex_mem));

    memory_stage u_memory (.clk_i, .reset, .run_i(run), .ex_mem_i(ex_mem),
        .dbg_addr_i(rd_addr_i), .dbg_data_o(mem_dbg), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .wb_we_o(wb_we));

    assign rb_word.word  = data_or_reg_i ? reg_dbg : mem_dbg;
    assign value_o       = rb_word.lanes[byte_sel_i];
    assign is_positive_o = $signed(value_o) > 8'sd0;  // 1 to 127 only

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic                         clk_i,
    input  logic                         reset,
    input  logic                         run_i,
    input  pipe_pkg::ex_mem_t            ex_mem_i,
    input  logic [pipe_pkg::DMEM_AW-1:0] dbg_addr_i,
    output logic [pipe_pkg::XLEN-1:0]    dbg_data_o,
    output logic [pipe_pkg::REG_AW-1:0]  wb_rd_o,
    output logic [pipe_pkg::XLEN-1:0]    wb_data_o,
    output logic                         wb_we_o
);
    import pipe_pkg::*;

    logic [XLEN-1:0]    dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] addr;
    logic [XLEN-1:0]    load_data;
    mem_wb_t            mem_wb_q;

    assign addr       = ex_mem_i.result[DMEM_AW+1:2];  // drop byte offset
    assign load_data  = ex_mem_i.ctrl.mem_read ? dmem[addr] : '0;
    assign dbg_data_o = dmem[dbg_addr_i];

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end else if (run_i && ex_mem_i.ctrl.mem_write) begin
            dmem[addr] <= ex_mem_i.store_data;
        end
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            mem_wb_q <= '0;
        end else if (run_i) begin
            mem_wb_q.reg_write  <= ex_mem_i.ctrl.reg_write;
            mem_wb_q.mem_to_reg <= ex_mem_i.ctrl.mem_to_reg;
            mem_wb_q.rd         <= ex_mem_i.rd;
            mem_wb_q.result     <= ex_mem_i.result;
            mem_wb_q.load_data  <= load_data;
        end
    end

    // writeback bundle
    assign wb_rd_o   = mem_wb_q.rd;
    assign wb_we_o   = mem_wb_q.reg_write;
    assign wb_data_o = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.result;

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                        clk_i,
    input  logic                        reset,
    input  logic                        run_i,
    input  pipe_pkg::id_ex_t            id_ex_i,
    input  logic [pipe_pkg::REG_AW-1:0] wb_rd_i,
    input  logic [pipe_pkg::XLEN-1:0]   wb_data_i,
    input  logic                        wb_we_i,
    output pipe_pkg::ex_mem_t           ex_mem_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0] fwd_a, fwd_b;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    vec_word_u       va, vb, vr;

    // nearest producer wins, EX/MEM before writeback
    function automatic logic [XLEN-1:0] forward(
        input logic [REG_AW-1:0] rs,
        input logic [XLEN-1:0]   reg_val,
        input ex_mem_t           exm,
        input logic [REG_AW-1:0] wrd,
        input logic [XLEN-1:0]   wdata,
        input logic              wwe
    );
        if (exm.ctrl.reg_write && exm.rd == rs)
            return exm.result;
        else if (wwe && wrd == rs)
            return wdata;
        else
            return reg_val;
    endfunction

    always_comb begin
        fwd_a = forward(id_ex_i.rs1, id_ex_i.rs1_data, ex_mem_o, wb_rd_i, wb_data_i, wb_we_i);
        fwd_b = forward(id_ex_i.rs2, id_ex_i.rs2_data, ex_mem_o, wb_rd_i, wb_data_i, wb_we_i);
    end

    assign op_b    = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : fwd_b;
    assign va.word = fwd_a;
    assign vb.word = op_b;

    // lane ALU, each byte wraps on its own
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (id_ex_i.ctrl.alu_op == VEC_SUB)
                vr.lanes[i] = va.lanes[i] - vb.lanes[i];
            else
                vr.lanes[i] = va.lanes[i] + vb.lanes[i];
        end
    end

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD:          result = fwd_a + op_b;  // also lw/sw address
            ALU_SUB:          result = fwd_a - op_b;
            ALU_AND:          result = fwd_a & op_b;
            ALU_OR:           result = fwd_a | op_b;
            VEC_ADD, VEC_SUB: result = vr.word;
            default:          result = fwd_a + op_b;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            ex_mem_o <= '0;
        end else if (run_i) begin
            ex_mem_o.ctrl       <= id_ex_i.ctrl;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.result     <= result;
            ex_mem_o.store_data <= fwd_b;  // forwarded rs2 for sw
        end
    end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                        clk_i,
    input  logic                        reset,
    input  logic                        run_i,
    input  pipe_pkg::if_id_t            if_id_i,
    input  logic [pipe_pkg::REG_AW-1:0] wb_rd_i,
    input  logic [pipe_pkg::XLEN-1:0]   wb_data_i,
    input  logic                        wb_we_i,
    input  logic [pipe_pkg::REG_AW-1:0] dbg_addr_i,
    output logic [pipe_pkg::XLEN-1:0]   dbg_data_o,
    output logic                        stall_o,
    output logic                        branch_taken_o,
    output logic [pipe_pkg::XLEN-1:0]   branch_target_o,
    output pipe_pkg::id_ex_t            id_ex_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0]   regs [2**REG_AW];
    logic [XLEN-1:0]   instr;
    logic [6:0]        opcode;
    logic [REG_AW-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]   rs1_val, rs2_val;
    logic [XLEN-1:0]   imm_i, imm_s, imm_b;
    logic              uses_rs2;
    ctrl_t             ctrl;

    assign instr  = if_id_i.instr;
    assign opcode = instr[6:0];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        ctrl = '0;
        if (if_id_i.valid) begin
            case (opcode)
                OP_R: begin
                    ctrl.reg_write = 1'b1;
                    case (instr[14:12])
                        F3_ADD:  ctrl.alu_op = (instr[31:25] == F7_SUB) ? ALU_SUB : ALU_ADD;
                        F3_AND:  ctrl.alu_op = ALU_AND;
                        F3_OR:   ctrl.alu_op = ALU_OR;
                        default: ctrl.reg_write = 1'b0;  // not in the subset
                    endcase
                end
                OP_IMM:   {ctrl.alu_src_imm, ctrl.reg_write} = 2'b11;
                OP_LOAD:  {ctrl.alu_src_imm, ctrl.reg_write, ctrl.mem_read, ctrl.mem_to_reg} = 4'hF;
                OP_STORE: {ctrl.alu_src_imm, ctrl.mem_write} = 2'b11;
                OP_VEC: begin
                    ctrl.reg_write = 1'b1;
                    case (instr[14:12])
                        F3_VADD: ctrl.alu_op = VEC_ADD;
                        F3_VSUB: ctrl.alu_op = VEC_SUB;
                        default: ctrl.reg_write = 1'b0;
                    endcase
                end
                default: ctrl = '0;  // beq has no work past decode
            endcase
            if (rd == '0)
                ctrl.reg_write = 1'b0;
        end
    end

    // same-cycle writeback goes straight to the readers
    assign rs1_val    = (wb_we_i && wb_rd_i == rs1) ? wb_data_i : regs[rs1];
    assign rs2_val    = (wb_we_i && wb_rd_i == rs2) ? wb_data_i : regs[rs2];
    assign dbg_data_o = regs[dbg_addr_i];  // readback port

    assign uses_rs2 = opcode inside {OP_R, OP_STORE, OP_BRANCH, OP_VEC};
    assign stall_o  = if_id_i.valid && id_ex_o.ctrl.mem_read && id_ex_o.ctrl.reg_write &&
                      (id_ex_o.rd == rs1 || (uses_rs2 && id_ex_o.rd == rs2));

    assign branch_taken_o  = if_id_i.valid && opcode == OP_BRANCH &&
                             rs1_val == rs2_val && !stall_o;
    assign branch_target_o = if_id_i.pc + imm_b;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_AW; i++)
                regs[i] <= '0;
        end else if (wb_we_i) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            id_ex_o <= '0;
        end else if (run_i) begin
            if (stall_o) begin
                id_ex_o <= '0;  // bubble into execute
            end else begin
                id_ex_o.ctrl     <= ctrl;
                id_ex_o.rs1      <= rs1;
                id_ex_o.rs2      <= rs2;
                id_ex_o.rd       <= rd;
                id_ex_o.rs1_data <= rs1_val;
                id_ex_o.rs2_data <= rs2_val;
                id_ex_o.imm      <= (opcode == OP_STORE) ? imm_s : imm_i;
            end
        end
    end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                         clk_i,
    input  logic                         reset,
    input  logic                         run_i,
    input  logic                         stall_i,
    input  logic                         branch_taken_i,
    input  logic [pipe_pkg::XLEN-1:0]    branch_target_i,
    input  logic                         imem_we_i,
    input  logic [pipe_pkg::IMEM_AW-1:0] imem_waddr_i,
    input  logic [pipe_pkg::XLEN-1:0]    imem_wdata_i,
    output pipe_pkg::if_id_t             if_id_o
);
    import pipe_pkg::*;

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] instr;

    assign instr = imem[pc_q[IMEM_AW+1:2]];  // word index from byte pc

    // written only by the loader before run
    always_ff @(posedge clk_i) begin
        if (imem_we_i)
            imem[imem_waddr_i] <= imem_wdata_i;
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            pc_q <= '0;
        end else if (run_i) begin
            if (branch_taken_i)
                pc_q <= branch_target_i;
            else if (!stall_i)
                pc_q <= pc_q + XLEN'(4);
        end
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            if_id_o <= '0;
        end else if (run_i) begin
            if (branch_taken_i) begin
                if_id_o <= '0;  // drop the slot behind beq
            end else if (!stall_i) begin
                if_id_o.valid <= 1'b1;
                if_id_o.pc    <= pc_q;
                if_id_o.instr <= instr;
            end
        end
    end

endmodule

// File: hw/program_loader.sv
`timescale 1ns/1ps

module program_loader (
    input  logic                         clk_i,
    input  logic                         reset,
    input  logic [7:0]                   instr_byte_i,
    output logic                         imem_we_o,
    output logic [pipe_pkg::IMEM_AW-1:0] imem_waddr_o,
    output logic [pipe_pkg::XLEN-1:0]    imem_wdata_o,
    output logic                         run_o
);
    import rv_isa_pkg::*;

    logic        loading_q;   // between start and end byte
    logic [1:0]  byte_cnt_q;  // byte position inside the word
    logic [23:0] word_q;      // first three bytes, lsb first
    logic        data_byte;

    assign data_byte    = loading_q && (instr_byte_i != LOAD_END_BYTE);
    assign imem_we_o    = data_byte && (byte_cnt_q == 2'd3);
    assign imem_wdata_o = {instr_byte_i, word_q};  // fourth byte is the top

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            loading_q    <= 1'b0;
            byte_cnt_q   <= 2'd0;
            imem_waddr_o <= '0;
            run_o        <= 1'b0;
        end else if (!loading_q) begin
            if (!run_o && instr_byte_i == LOAD_START_BYTE) begin
                loading_q  <= 1'b1;
                byte_cnt_q <= 2'd0;
            end
        end else if (!data_byte) begin
            loading_q <= 1'b0;  // end byte seen
            run_o     <= 1'b1;  // held until reset
        end else begin
            byte_cnt_q <= byte_cnt_q + 2'd1;  // wraps after the fourth byte
            if (byte_cnt_q == 2'd3)
                imem_waddr_o <= imem_waddr_o + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_byte)
            word_q <= {instr_byte_i, word_q[23:8]};
    end

endmodule

// File: hw/pipe_pkg.sv
package pipe_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = 6;
    localparam int DMEM_DEPTH = 32;
    localparam int DMEM_AW    = 5;

    typedef struct packed {
        rv_isa_pkg::alu_op_e alu_op;
        logic                alu_src_imm;  // operand b from immediate
        logic                reg_write;    // never set for rd x0
        logic                mem_read;
        logic                mem_write;
        logic                mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;  // i or s format
    } id_ex_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   result;      // alu result or byte address
        logic [XLEN-1:0]   store_data;
    } ex_mem_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_to_reg;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   load_data;
    } mem_wb_t;

endpackage

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'b0110011;  // add, sub, and, or
    localparam logic [6:0] OP_IMM    = 7'b0010011;  // addi only
    localparam logic [6:0] OP_LOAD   = 7'b0000011;  // lw
    localparam logic [6:0] OP_STORE  = 7'b0100011;  // sw
    localparam logic [6:0] OP_BRANCH = 7'b1100011;  // beq
    localparam logic [6:0] OP_VEC    = 7'b1010111;  // byte-lane vector ops

    localparam logic [2:0] F3_ADD  = 3'b000;  // add and sub share it
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_VADD = 3'b000;  // vadd.b
    localparam logic [2:0] F3_VSUB = 3'b001;  // vsub.b
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // serial loader framing, 0xff may not appear inside a program
    localparam logic [7:0] LOAD_START_BYTE = 8'hFE;
    localparam logic [7:0] LOAD_END_BYTE   = 8'hFF;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        VEC_ADD = 3'd4,  // four 8-bit lanes, no carry between lanes
        VEC_SUB = 3'd5
    } alu_op_e;

    // one word seen either as a scalar or as four bytes
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;  // lane 0 is bits 7:0
    } vec_word_u;

endpackage
